// ==== logic/axi_adapter_defines.svh ====
`ifndef AXI_ADAPTER_DEFINES_SVH
`define AXI_ADAPTER_DEFINES_SVH

// ------------------------------------------------------------
// data path geometry
// ------------------------------------------------------------
// one AXI beat carries exactly one data word
`define AA_WORD_W        64
`define AA_LINE_WORDS    4

// a line is 4 words of 8 bytes, so 32 bytes
`define AA_LINE_OFFSET_W 5
`define AA_WORD_IDX_W    2

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------
`define AA_ADDR_W        32
`define AA_ID_W          4

`endif

// ==== logic/axi_adapter_pkg.sv ====
`include "axi_adapter_defines.svh"

package axi_adapter_pkg;

  // ------------------------------------------------------------
  // request kind
  // ------------------------------------------------------------
  // the cache asks either for one word or for the whole line
  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  // ------------------------------------------------------------
  // data types
  // ------------------------------------------------------------
  // one beat worth of data
  typedef logic [`AA_WORD_W-1:0] word_t;

  // byte enables of one word
  typedef logic [`AA_WORD_W/8-1:0] strb_t;

  // full line, word 0 in the low bits
  typedef word_t [`AA_LINE_WORDS-1:0] line_t;

  // byte enables for every word of a line
  typedef strb_t [`AA_LINE_WORDS-1:0] line_strb_t;

endpackage

// ==== logic/beat_ctrl_if.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

// hands one burst from the request controller to a beat engine
interface beat_ctrl_if;
  logic                      start;
  logic                      line_mode;
  logic [`AA_WORD_IDX_W-1:0] word_idx;
  logic                      done;

  // controller side towards the write engine
  modport ctrl (
    output start,
    output line_mode,
    input  done
  );

  // controller side towards the read engine, also passes the critical index
  modport ctrl_rd (
    output start,
    output line_mode,
    output word_idx,
    input  done
  );

  modport wr_engine (
    input  start,
    input  line_mode,
    output done
  );

  modport rd_engine (
    input  start,
    input  line_mode,
    input  word_idx,
    output done
  );
endinterface

// ==== logic/request_ctrl.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

module request_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // cache request
  input  logic                          req_i,
  input  logic                          we_i,
  input  axi_adapter_pkg::req_kind_e    kind_i,
  input  logic [`AA_ADDR_W-1:0]         addr_i,
  input  logic [1:0]                    size_i,
  input  logic [`AA_ID_W-1:0]           id_i,
  output logic                          gnt_o,
  output logic                          busy_o,
  output logic                          valid_o,
  output logic [`AA_ID_W-1:0]           id_o,
  // AW channel
  output logic                          aw_valid_o,
  input  logic                          aw_ready_i,
  output logic [`AA_ADDR_W-1:0]         aw_addr_o,
  output logic [7:0]                    aw_len_o,
  output logic [2:0]                    aw_size_o,
  output logic [`AA_ID_W-1:0]           aw_id_o,
  // B channel
  input  logic                          b_valid_i,
  output logic                          b_ready_o,
  input  logic [`AA_ID_W-1:0]           b_id_i,
  input  logic [1:0]                    b_resp_i,
  // AR channel
  output logic                          ar_valid_o,
  input  logic                          ar_ready_i,
  output logic [`AA_ADDR_W-1:0]         ar_addr_o,
  output logic [7:0]                    ar_len_o,
  output logic [2:0]                    ar_size_o,
  output logic [`AA_ID_W-1:0]           ar_id_o,
  // id captured by the read engine on the last beat
  input  logic [`AA_ID_W-1:0]           rd_id_i,
  beat_ctrl_if.ctrl                     wr_ctl,
  beat_ctrl_if.ctrl_rd                  rd_ctl
);

  typedef enum logic [2:0] {
    IDLE,
    WR_ADDR,
    WR_RESP,
    RD_ADDR,
    RD_DATA,
    RD_DONE
  } state_e;

  state_e     state_q, state_d;
  logic       aw_done_q, aw_done_d;
  logic       w_done_q, w_done_d;
  logic       aw_ok, w_ok;
  logic       is_line;
  logic [7:0] burst_len;

  assign is_line   = (kind_i == axi_adapter_pkg::REQ_LINE);
  assign burst_len = is_line ? 8'(`AA_LINE_WORDS - 1) : 8'd0;
  assign busy_o    = (state_q != IDLE);

  // engines are kicked off in the same cycle the request is seen
  assign wr_ctl.start     = (state_q == IDLE) && req_i && we_i;
  assign wr_ctl.line_mode = is_line;
  assign rd_ctl.start     = (state_q == IDLE) && req_i && !we_i;
  assign rd_ctl.line_mode = is_line;
  assign rd_ctl.word_idx  = addr_i[`AA_LINE_OFFSET_W-1 -: `AA_WORD_IDX_W];

  // ------------------------------------------------------------
  // address channels
  // ------------------------------------------------------------
  assign aw_valid_o = (state_q == WR_ADDR) && !aw_done_q;
  assign aw_addr_o  = addr_i;
  assign aw_len_o   = burst_len;
  assign aw_size_o  = {1'b0, size_i};
  assign aw_id_o    = id_i;

  // a line read starts at the line base, a single read at the word itself
  assign ar_valid_o = (state_q == RD_ADDR);
  assign ar_addr_o  = is_line ?
                      {addr_i[`AA_ADDR_W-1:`AA_LINE_OFFSET_W], {`AA_LINE_OFFSET_W{1'b0}}} :
                      addr_i;
  assign ar_len_o   = burst_len;
  assign ar_size_o  = {1'b0, size_i};
  assign ar_id_o    = id_i;

  assign b_ready_o = (state_q == WR_RESP);
  assign id_o      = (state_q == RD_DONE) ? rd_id_i : b_id_i;

  // each half of a write counts once, whichever finishes first
  assign aw_ok = aw_done_q || (aw_valid_o && aw_ready_i);
  assign w_ok  = w_done_q || wr_ctl.done;

  always_comb begin
    state_d   = state_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    gnt_o     = 1'b0;
    valid_o   = 1'b0;

    case (state_q)
      IDLE: begin
        aw_done_d = 1'b0;
        w_done_d  = 1'b0;
        if (req_i) begin
          state_d = we_i ? WR_ADDR : RD_ADDR;
        end
      end
      WR_ADDR: begin
        aw_done_d = aw_ok;
        w_done_d  = w_ok;
        if (aw_ok && w_ok) begin
          gnt_o   = 1'b1;
          state_d = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_valid_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
        end
      end
      RD_ADDR: begin
        if (ar_ready_i) begin
          gnt_o   = 1'b1;
          state_d = RD_DATA;
        end
      end
      RD_DATA: begin
        if (rd_ctl.done) begin
          state_d = RD_DONE;
        end
      end
      RD_DONE: begin
        // line buffer is complete one cycle after the last beat
        valid_o = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
    end
  end

  // ------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------
  // the cache holds its inputs, so the address payload must not move either
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o));

  // an engine may only finish while the controller waits for it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ctl.done |-> state_q == WR_ADDR);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_ctl.done |-> state_q == RD_DATA);

  // there is no error path back to the cache, so memory must answer OKAY
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && b_ready_o |-> b_resp_i == 2'b00);

endmodule

// ==== logic/write_beat_sender.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

module write_beat_sender (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  beat_ctrl_if.wr_engine                  ctl,
  input  axi_adapter_pkg::line_t          wdata_i,
  input  axi_adapter_pkg::line_strb_t     be_i,
  // W channel
  output logic                            w_valid_o,
  input  logic                            w_ready_i,
  output axi_adapter_pkg::word_t          w_data_o,
  output axi_adapter_pkg::strb_t          w_strb_o,
  output logic                            w_last_o
);

  localparam logic [`AA_WORD_IDX_W-1:0] LastBeat = `AA_WORD_IDX_W'(`AA_LINE_WORDS - 1);

  logic                      active_q;
  logic                      line_q;
  logic [`AA_WORD_IDX_W-1:0] beat_q;
  logic                      w_hs;

  assign w_valid_o = active_q;
  assign w_hs      = w_valid_o && w_ready_i;

  // beat_q never leaves 0 in a single write, so word and strobe 0 go out
  assign w_data_o = wdata_i[beat_q];
  assign w_strb_o = be_i[beat_q];
  assign w_last_o = !line_q || (beat_q == LastBeat);

  assign ctl.done = w_hs && w_last_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      line_q   <= 1'b0;
      beat_q   <= '0;
    end else if (ctl.start) begin
      active_q <= 1'b1;
      line_q   <= ctl.line_mode;
      beat_q   <= '0;
    end else if (w_hs) begin
      if (w_last_o) begin
        active_q <= 1'b0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------
  // a stalled beat keeps its payload until it is taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o)
      && $stable(w_last_o));

  // controller only starts a new burst after the previous one drained
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctl.start |-> !active_q);

endmodule

// ==== logic/read_line_collector.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

module read_line_collector (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  beat_ctrl_if.rd_engine                ctl,
  // R channel
  input  logic                          r_valid_i,
  output logic                          r_ready_o,
  input  axi_adapter_pkg::word_t        r_data_i,
  input  logic [`AA_ID_W-1:0]           r_id_i,
  input  logic                          r_last_i,
  // collected line and its id
  output axi_adapter_pkg::line_t        rdata_o,
  output logic [`AA_ID_W-1:0]           rd_id_o,
  // requested word, passed through as it arrives
  output axi_adapter_pkg::word_t        critical_word_o,
  output logic                          critical_word_valid_o
);

  localparam logic [`AA_WORD_IDX_W-1:0] LastBeat = `AA_WORD_IDX_W'(`AA_LINE_WORDS - 1);

  logic                      active_q;
  logic                      line_q;
  logic [`AA_WORD_IDX_W-1:0] beat_q;
  logic [`AA_WORD_IDX_W-1:0] crit_idx_q;
  logic [`AA_WORD_IDX_W-1:0] slot;
  logic                      r_hs;
  axi_adapter_pkg::line_t    line_buf_q;
  logic [`AA_ID_W-1:0]       id_q;

  assign r_ready_o = active_q;
  assign r_hs      = r_valid_i && r_ready_o;
  assign ctl.done  = r_hs && r_last_i;

  // single read lands in word 0
  assign slot = line_q ? beat_q : '0;

  assign critical_word_valid_o = r_hs && line_q && (beat_q == crit_idx_q);
  assign critical_word_o       = r_data_i;

  assign rdata_o = line_buf_q;
  assign rd_id_o = id_q;

  // ------------------------------------------------------------
  // burst control
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      line_q     <= 1'b0;
      beat_q     <= '0;
      crit_idx_q <= '0;
    end else if (ctl.start) begin
      active_q   <= 1'b1;
      line_q     <= ctl.line_mode;
      beat_q     <= '0;
      crit_idx_q <= ctl.word_idx;
    end else if (r_hs) begin
      beat_q <= beat_q + 1'b1;
      if (r_last_i) begin
        active_q <= 1'b0;
      end
    end
  end

  // line buffer and id
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      line_buf_q[slot] <= r_data_i;
    end
    if (ctl.done) begin
      id_q <= r_id_i;
    end
  end

  // at most one line worth of beats, the final one tagged last
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_hs && (!line_q || beat_q == LastBeat) |-> r_last_i);

endmodule

// ==== logic/axi_adapter_top.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

module axi_adapter_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // cache side
  input  logic                          req_i,
  input  logic                          we_i,
  input  axi_adapter_pkg::req_kind_e    kind_i,
  input  logic [`AA_ADDR_W-1:0]         addr_i,
  input  logic [1:0]                    size_i,
  input  logic [`AA_ID_W-1:0]           id_i,
  input  axi_adapter_pkg::line_t        wdata_i,
  input  axi_adapter_pkg::line_strb_t   be_i,
  output logic                          gnt_o,
  output logic                          busy_o,
  output logic                          valid_o,
  output logic [`AA_ID_W-1:0]           id_o,
  output axi_adapter_pkg::line_t        rdata_o,
  output axi_adapter_pkg::word_t        critical_word_o,
  output logic                          critical_word_valid_o,
  // AW
  output logic                          aw_valid_o,
  input  logic                          aw_ready_i,
  output logic [`AA_ADDR_W-1:0]         aw_addr_o,
  output logic [7:0]                    aw_len_o,
  output logic [2:0]                    aw_size_o,
  output logic [`AA_ID_W-1:0]           aw_id_o,
  // W
  output logic                          w_valid_o,
  input  logic                          w_ready_i,
  output axi_adapter_pkg::word_t        w_data_o,
  output axi_adapter_pkg::strb_t        w_strb_o,
  output logic                          w_last_o,
  // B
  input  logic                          b_valid_i,
  output logic                          b_ready_o,
  input  logic [`AA_ID_W-1:0]           b_id_i,
  input  logic [1:0]                    b_resp_i,
  // AR
  output logic                          ar_valid_o,
  input  logic                          ar_ready_i,
  output logic [`AA_ADDR_W-1:0]         ar_addr_o,
  output logic [7:0]                    ar_len_o,
  output logic [2:0]                    ar_size_o,
  output logic [`AA_ID_W-1:0]           ar_id_o,
  // R
  input  logic                          r_valid_i,
  output logic                          r_ready_o,
  input  axi_adapter_pkg::word_t        r_data_i,
  input  logic [`AA_ID_W-1:0]           r_id_i,
  input  logic                          r_last_i
);

  logic [`AA_ID_W-1:0] rd_id;

  beat_ctrl_if wr_ctl ();
  beat_ctrl_if rd_ctl ();

  request_ctrl u_request_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .we_i       (we_i),
    .kind_i     (kind_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .gnt_o      (gnt_o),
    .busy_o     (busy_o),
    .valid_o    (valid_o),
    .id_o       (id_o),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_size_o  (aw_size_o),
    .aw_id_o    (aw_id_o),
    .b_valid_i  (b_valid_i),
    .b_ready_o  (b_ready_o),
    .b_id_i     (b_id_i),
    .b_resp_i   (b_resp_i),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_o  (ar_addr_o),
    .ar_len_o   (ar_len_o),
    .ar_size_o  (ar_size_o),
    .ar_id_o    (ar_id_o),
    .rd_id_i    (rd_id),
    .wr_ctl     (wr_ctl.ctrl),
    .rd_ctl     (rd_ctl.ctrl_rd)
  );

  write_beat_sender u_write_beat_sender (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ctl       (wr_ctl.wr_engine),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .w_valid_o (w_valid_o),
    .w_ready_i (w_ready_i),
    .w_data_o  (w_data_o),
    .w_strb_o  (w_strb_o),
    .w_last_o  (w_last_o)
  );

  read_line_collector u_read_line_collector (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .ctl                   (rd_ctl.rd_engine),
    .r_valid_i             (r_valid_i),
    .r_ready_o             (r_ready_o),
    .r_data_i              (r_data_i),
    .r_id_i                (r_id_i),
    .r_last_i              (r_last_i),
    .rdata_o               (rdata_o),
    .rd_id_o               (rd_id),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

endmodule

// ==== bench/axi_mem_slave.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

module axi_mem_slave #(
  parameter int SEED = 80438
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // AW
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic [`AA_ADDR_W-1:0]  aw_addr_i,
  input  logic [`AA_ID_W-1:0]    aw_id_i,
  // W
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  axi_adapter_pkg::word_t w_data_i,
  input  axi_adapter_pkg::strb_t w_strb_i,
  input  logic                   w_last_i,
  // B
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output logic [`AA_ID_W-1:0]    b_id_o,
  output logic [1:0]             b_resp_o,
  // AR
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  logic [`AA_ADDR_W-1:0]  ar_addr_i,
  input  logic [7:0]             ar_len_i,
  input  logic [`AA_ID_W-1:0]    ar_id_i,
  // R
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output axi_adapter_pkg::word_t r_data_o,
  output logic [`AA_ID_W-1:0]    r_id_o,
  output logic                   r_last_o
);

  // 16 lines of 4 words, indexed by address bits 8:3
  localparam int MemWords = 64;

  integer                 seed;
  axi_adapter_pkg::word_t mem [MemWords];
  logic                   aw_held;
  logic                   b_pend;
  logic                   ar_held;
  logic [5:0]             wr_ptr;
  logic [5:0]             rd_ptr;
  logic [7:0]             rd_beat;
  logic [7:0]             rd_len;
  logic [`AA_ID_W-1:0]    wr_id;
  logic [`AA_ID_W-1:0]    rd_id;

  initial seed = SEED;

  assign b_resp_o = 2'b00;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      b_id_o     <= '0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_id_o     <= '0;
      r_last_o   <= 1'b0;
      aw_held    <= 1'b0;
      b_pend     <= 1'b0;
      ar_held    <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      rd_beat    <= '0;
      rd_len     <= '0;
      wr_id      <= '0;
      rd_id      <= '0;
      // contents follow the word index, same rule as the reference memory
      for (int i = 0; i < MemWords; i++) begin
        mem[i] <= {32'h5A5A_0000 + 32'(i), ~(32'(i) << 3)};
      end
    end else begin
      // ------------------------------------------------------------
      // write side
      // ------------------------------------------------------------
      if (aw_valid_i && aw_ready_o) begin
        aw_held    <= 1'b1;
        aw_ready_o <= 1'b0;
        wr_ptr     <= aw_addr_i[8:3];
        wr_id      <= aw_id_i;
      end else begin
        aw_ready_o <= !aw_held && 1'($random(seed));
      end

      // data is only taken once the address is known
      if (w_valid_i && w_ready_o) begin
        for (int b = 0; b < `AA_WORD_W / 8; b++) begin
          if (w_strb_i[b]) begin
            mem[wr_ptr][8*b +: 8] <= w_data_i[8*b +: 8];
          end
        end
        wr_ptr <= wr_ptr + 6'd1;
        if (w_last_i) begin
          b_pend    <= 1'b1;
          w_ready_o <= 1'b0;
        end else begin
          w_ready_o <= 1'($random(seed));
        end
      end else begin
        w_ready_o <= aw_held && !b_pend && 1'($random(seed));
      end

      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        b_pend    <= 1'b0;
        aw_held   <= 1'b0;
      end else if (b_pend && !b_valid_o) begin
        b_valid_o <= 1'($random(seed));
        b_id_o    <= wr_id;
      end

      // ------------------------------------------------------------
      // read side
      // ------------------------------------------------------------
      if (ar_valid_i && ar_ready_o) begin
        ar_held    <= 1'b1;
        ar_ready_o <= 1'b0;
        rd_ptr     <= ar_addr_i[8:3];
        rd_len     <= ar_len_i;
        rd_beat    <= '0;
        rd_id      <= ar_id_i;
      end else begin
        ar_ready_o <= !ar_held && 1'($random(seed));
      end

      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        rd_ptr    <= rd_ptr + 6'd1;
        rd_beat   <= rd_beat + 8'd1;
        if (r_last_o) begin
          ar_held <= 1'b0;
        end
      end else if (ar_held && !r_valid_o && 1'($random(seed))) begin
        r_valid_o <= 1'b1;
        r_data_o  <= mem[rd_ptr];
        r_last_o  <= (rd_beat == rd_len);
        r_id_o    <= rd_id;
      end
    end
  end

endmodule

// ==== bench/tb_axi_adapter.sv ====
`timescale 1ns/1ps
`include "axi_adapter_defines.svh"

module tb_axi_adapter;

  localparam int NumReq     = 200;
  localparam int TimeoutCyc = NumReq * 40;
  localparam int MemWords   = 64;

  logic                        clk_i;
  logic                        rst_ni;
  // cache side
  logic                        req_i;
  logic                        we_i;
  axi_adapter_pkg::req_kind_e  kind_i;
  logic [`AA_ADDR_W-1:0]       addr_i;
  logic [1:0]                  size_i;
  logic [`AA_ID_W-1:0]         id_i;
  axi_adapter_pkg::line_t      wdata_i;
  axi_adapter_pkg::line_strb_t be_i;
  logic                        gnt_o;
  logic                        busy_o;
  logic                        valid_o;
  logic [`AA_ID_W-1:0]         id_o;
  axi_adapter_pkg::line_t      rdata_o;
  axi_adapter_pkg::word_t      critical_word_o;
  logic                        critical_word_valid_o;
  // AXI side
  logic                        aw_valid_o;
  logic                        aw_ready_i;
  logic [`AA_ADDR_W-1:0]       aw_addr_o;
  logic [7:0]                  aw_len_o;
  logic [2:0]                  aw_size_o;
  logic [`AA_ID_W-1:0]         aw_id_o;
  logic                        w_valid_o;
  logic                        w_ready_i;
  axi_adapter_pkg::word_t      w_data_o;
  axi_adapter_pkg::strb_t      w_strb_o;
  logic                        w_last_o;
  logic                        b_valid_i;
  logic                        b_ready_o;
  logic [`AA_ID_W-1:0]         b_id_i;
  logic [1:0]                  b_resp_i;
  logic                        ar_valid_o;
  logic                        ar_ready_i;
  logic [`AA_ADDR_W-1:0]       ar_addr_o;
  logic [7:0]                  ar_len_o;
  logic [2:0]                  ar_size_o;
  logic [`AA_ID_W-1:0]         ar_id_o;
  logic                        r_valid_i;
  logic                        r_ready_o;
  axi_adapter_pkg::word_t      r_data_i;
  logic [`AA_ID_W-1:0]         r_id_i;
  logic                        r_last_i;

  integer                      seed;
  int                          cycles = 0;
  int                          done_count;
  axi_adapter_pkg::word_t      ref_mem [MemWords];

  // expectations for the request in flight, read by the bus monitor
  logic [`AA_ADDR_W-1:0]       exp_aw_addr;
  logic [`AA_ADDR_W-1:0]       exp_ar_addr;
  logic [7:0]                  exp_len;
  int                          exp_w_beats;
  int                          w_beats;
  int                          crit_count;
  axi_adapter_pkg::word_t      exp_crit;

  axi_adapter_top u_axi_adapter_top (.*);

  axi_mem_slave #(.SEED(80438)) u_axi_mem_slave (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_valid_i (aw_valid_o),
    .aw_ready_o (aw_ready_i),
    .aw_addr_i  (aw_addr_o),
    .aw_id_i    (aw_id_o),
    .w_valid_i  (w_valid_o),
    .w_ready_o  (w_ready_i),
    .w_data_i   (w_data_o),
    .w_strb_i   (w_strb_o),
    .w_last_i   (w_last_o),
    .b_valid_o  (b_valid_i),
    .b_ready_i  (b_ready_o),
    .b_id_o     (b_id_i),
    .b_resp_o   (b_resp_i),
    .ar_valid_i (ar_valid_o),
    .ar_ready_o (ar_ready_i),
    .ar_addr_i  (ar_addr_o),
    .ar_len_i   (ar_len_o),
    .ar_id_i    (ar_id_o),
    .r_valid_o  (r_valid_i),
    .r_ready_i  (r_ready_o),
    .r_data_o   (r_data_i),
    .r_id_o     (r_id_i),
    .r_last_o   (r_last_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  function automatic axi_adapter_pkg::word_t fill_word(input int idx);
    return {32'h5A5A_0000 + 32'(idx), ~(32'(idx) << 3)};
  endfunction

  task automatic check_reset_outputs();
    check_value("busy_o", 256'(busy_o), 256'(0));
    check_value("gnt_o", 256'(gnt_o), 256'(0));
    check_value("valid_o", 256'(valid_o), 256'(0));
    check_value("critical_word_valid_o", 256'(critical_word_valid_o), 256'(0));
    check_value("aw_valid_o", 256'(aw_valid_o), 256'(0));
    check_value("w_valid_o", 256'(w_valid_o), 256'(0));
    check_value("ar_valid_o", 256'(ar_valid_o), 256'(0));
    check_value("b_ready_o", 256'(b_ready_o), 256'(0));
    check_value("r_ready_o", 256'(r_ready_o), 256'(0));
  endtask

  // byte merge of a granted write into the reference memory
  task automatic merge_write(input axi_adapter_pkg::req_kind_e kind,
                             input logic [`AA_ADDR_W-1:0] addr,
                             input axi_adapter_pkg::line_t wdata,
                             input axi_adapter_pkg::line_strb_t be);
    int nwords;
    int first;
    nwords = (kind == axi_adapter_pkg::REQ_LINE) ? `AA_LINE_WORDS : 1;
    first  = int'(addr[8:3]);
    for (int k = 0; k < nwords; k++) begin
      for (int b = 0; b < `AA_WORD_W / 8; b++) begin
        if (be[k][b]) begin
          ref_mem[first + k][8*b +: 8] = wdata[k][8*b +: 8];
        end
      end
    end
  endtask

  task automatic run_request(input logic we, input axi_adapter_pkg::req_kind_e kind,
                             input logic [`AA_ADDR_W-1:0] addr,
                             input logic [`AA_ID_W-1:0] id,
                             input axi_adapter_pkg::line_t wdata,
                             input axi_adapter_pkg::line_strb_t be);
    int                     gnts;
    bit                     finished;
    bit                     accepted;
    bit                     is_line;
    int                     base;
    axi_adapter_pkg::line_t exp_line;
    gnts        = 0;
    finished    = 1'b0;
    accepted    = 1'b0;
    is_line     = (kind == axi_adapter_pkg::REQ_LINE);
    base        = int'(addr[8:5]) * `AA_LINE_WORDS;
    exp_len     = is_line ? 8'd3 : 8'd0;
    exp_aw_addr = addr;
    exp_ar_addr = is_line ? {addr[`AA_ADDR_W-1:5], 5'b0} : addr;
    exp_w_beats = is_line ? `AA_LINE_WORDS : 1;
    w_beats     = 0;
    crit_count  = 0;
    exp_crit    = ref_mem[base + int'(addr[4:3])];
    for (int k = 0; k < `AA_LINE_WORDS; k++) begin
      exp_line[k] = is_line ? ref_mem[base + k] : ref_mem[int'(addr[8:3])];
    end

    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    kind_i  <= kind;
    addr_i  <= addr;
    size_i  <= 2'd3;
    id_i    <= id;
    wdata_i <= wdata;
    be_i    <= be;

    while (!finished) begin
      @(negedge clk_i);
      // busy rises the cycle after the request is seen and stays up through valid_o
      check_value("busy_o", 256'(busy_o), 256'(accepted));
      accepted = 1'b1;
      if (gnt_o) begin
        gnts++;
        if (we) begin
          merge_write(kind, addr, wdata, be);
        end
      end
      if (valid_o) begin
        finished = 1'b1;
        // a missing or repeated grant before the response shows up here
        check_value("gnt_o count", 256'(gnts), 256'(1));
        check_value("id_o", 256'(id_o), 256'(id));
        if (we) begin
          check_value("w beat count", 256'(w_beats), 256'(exp_w_beats));
        end else if (is_line) begin
          check_value("rdata_o", 256'(rdata_o), 256'(exp_line));
          check_value("critical_word_valid_o count", 256'(crit_count), 256'(1));
        end else begin
          check_value("rdata_o[0]", 256'(rdata_o[0]), 256'(exp_line[0]));
          check_value("critical_word_valid_o count", 256'(crit_count), 256'(0));
        end
      end else begin
        @(posedge clk_i);
        if (gnts != 0) begin
          req_i <= 1'b0;
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // bus monitor
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (aw_valid_o && aw_ready_i) begin
        check_value("aw_addr_o", 256'(aw_addr_o), 256'(exp_aw_addr));
        check_value("aw_len_o", 256'(aw_len_o), 256'(exp_len));
        check_value("aw_size_o", 256'(aw_size_o), 256'(3));
      end
      if (ar_valid_o && ar_ready_i) begin
        check_value("ar_addr_o", 256'(ar_addr_o), 256'(exp_ar_addr));
        check_value("ar_len_o", 256'(ar_len_o), 256'(exp_len));
        check_value("ar_size_o", 256'(ar_size_o), 256'(3));
      end
      if (w_valid_o && w_ready_i) begin
        w_beats = w_beats + 1;
        check_value("w_last_o", 256'(w_last_o), 256'(w_beats == exp_w_beats));
      end
      if (critical_word_valid_o) begin
        crit_count = crit_count + 1;
        check_value("critical_word_o", 256'(critical_word_o), 256'(exp_crit));
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCyc) begin
      $display("timeout: %0d of %0d requests done after %0d cycles",
               done_count, NumReq, cycles);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    axi_adapter_pkg::req_kind_e  kind;
    axi_adapter_pkg::line_t      wdata;
    axi_adapter_pkg::line_strb_t be;
    logic [3:0]                  line_idx;
    logic [1:0]                  word_idx;
    logic [`AA_ADDR_W-1:0]       waddr;
    logic [`AA_ADDR_W-1:0]       raddr;

    seed       = 80438;
    done_count = 0;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    kind_i     = axi_adapter_pkg::REQ_SINGLE;
    addr_i     = '0;
    size_i     = 2'd3;
    id_i       = '0;
    wdata_i    = '0;
    be_i       = '0;
    for (int i = 0; i < MemWords; i++) begin
      ref_mem[i] = fill_word(i);
    end

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_reset_outputs();

    // each write is read back from the same line
    for (int n = 0; n < NumReq / 2; n++) begin
      kind     = ($random(seed) & 1) ? axi_adapter_pkg::REQ_LINE : axi_adapter_pkg::REQ_SINGLE;
      line_idx = 4'($random(seed));
      word_idx = 2'($random(seed));
      for (int k = 0; k < `AA_LINE_WORDS; k++) begin
        wdata[k] = {32'($random(seed)), 32'($random(seed))};
        be[k]    = 8'($random(seed));
      end
      raddr = {23'b0, line_idx, word_idx, 3'b000};
      waddr = (kind == axi_adapter_pkg::REQ_LINE) ? {23'b0, line_idx, 5'b0} : raddr;
      run_request(1'b1, kind, waddr, 4'($random(seed)), wdata, be);
      done_count++;
      run_request(1'b0, kind, raddr, 4'($random(seed)), '0, '0);
      done_count++;
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== axi_adapter.f ====
+incdir+logic
logic/axi_adapter_pkg.sv
logic/beat_ctrl_if.sv
logic/request_ctrl.sv
logic/write_beat_sender.sv
logic/read_line_collector.sv
logic/axi_adapter_top.sv
bench/axi_mem_slave.sv
bench/tb_axi_adapter.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_axi_adapter
FILELIST  := axi_adapter.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
